// File: Bender.yml
package:
  name: sdram_ctrl

sources:
  - include_dirs:
      - .
    files:
      - sdram_cmd_pkg.sv
      - sdram_req_pkg.sv
      - sdram_init.sv
      - sdram_aref.sv
      - sdram_read.sv
      - sdram_arbiter.sv
      - sdram_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sdram_ctrl_sva.sv
      - tb_sdram_ctrl.sv

// File: compile.f
+incdir+.
sdram_cmd_pkg.sv
sdram_req_pkg.sv
sdram_init.sv
sdram_aref.sv
sdram_read.sv
sdram_arbiter.sv
sdram_ctrl_top.sv
sdram_ctrl_sva.sv
tb_sdram_ctrl.sv

// File: sdram_arbiter.sv
module sdram_arbiter (
	input  logic                    S_CLK,
	input  logic                    RST_N,
	input  logic                    init_done_pulse,
	input  logic                    rd_req,
	input  logic                    aref_pend,
	input  logic                    aref_done,
	input  logic                    rd_yield,
	input  logic                    rd_done,
	input  sdram_cmd_pkg::cmd_bus_t init_cmd,
	input  sdram_cmd_pkg::cmd_bus_t aref_cmd,
	input  sdram_cmd_pkg::cmd_bus_t read_cmd,
	output logic                    aref_start,
	output logic                    read_start,
	output logic                    init_done,
	output sdram_cmd_pkg::cmd_bus_t sdram
);

	sdram_req_pkg::grant_e   grant;
	logic                    rd_pend; // request parked behind a refresh
	logic                    resume;  // read yielded with bursts left
	sdram_cmd_pkg::cmd_bus_t cmd_sel;

	always_comb begin
		case (grant)
			sdram_req_pkg::G_INIT: cmd_sel = init_cmd;
			sdram_req_pkg::G_AREF: cmd_sel = aref_cmd;
			sdram_req_pkg::G_READ: cmd_sel = read_cmd;
			default:               cmd_sel = sdram_cmd_pkg::CMD_IDLE;
		endcase
	end

	// ----------------------------------------------------------
	// grant FSM, idle is the only decision point
	// ----------------------------------------------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			grant      <= sdram_req_pkg::G_INIT;
			rd_pend    <= 1'b0;
			resume     <= 1'b0;
			aref_start <= 1'b0;
			read_start <= 1'b0;
			init_done  <= 1'b0;
			sdram      <= sdram_cmd_pkg::CMD_IDLE;
		end else begin
			aref_start <= 1'b0;
			read_start <= 1'b0;
			sdram      <= cmd_sel; // pins lag the engines by one cycle
			case (grant)
				sdram_req_pkg::G_INIT: begin
					if (init_done_pulse) begin
						grant     <= sdram_req_pkg::G_IDLE;
						init_done <= 1'b1;
					end
				end
				sdram_req_pkg::G_IDLE: begin
					if (aref_pend) begin
						grant      <= sdram_req_pkg::G_AREF;
						aref_start <= 1'b1;
						rd_pend    <= rd_pend | (rd_req & ~resume);
					end else if (rd_req || rd_pend || resume) begin
						grant      <= sdram_req_pkg::G_READ;
						read_start <= 1'b1;
						rd_pend    <= 1'b0;
						resume     <= 1'b0;
					end
				end
				sdram_req_pkg::G_AREF: begin
					rd_pend <= rd_pend | (rd_req & ~resume);
					if (aref_done)
						grant <= sdram_req_pkg::G_IDLE;
				end
				sdram_req_pkg::G_READ: begin
					if (rd_yield) begin
						grant  <= sdram_req_pkg::G_IDLE;
						resume <= 1'b1;
					end else if (rd_done) begin
						grant <= sdram_req_pkg::G_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: sdram_aref.sv
`include "sdram_params.svh"

module sdram_aref (
	input  logic                    S_CLK,
	input  logic                    RST_N,
	input  logic                    enable,
	input  logic                    start,
	output logic                    pend,
	output logic                    done,
	output sdram_cmd_pkg::cmd_bus_t cmd
);

	localparam int TW = $clog2(`SDRAM_REF_PERIOD);
	localparam int FW = $clog2(`SDRAM_TRFC + 1);

	typedef enum logic [1:0] {A_IDLE, A_AREF, A_RFC} aref_e;

	aref_e         state;
	logic [TW-1:0] tmr;     // refresh interval
	logic [FW-1:0] rfc_cnt;
	logic          expire;

	assign expire = enable && (tmr == TW'(`SDRAM_REF_PERIOD - 1));

	// ----------------------------------------------------------
	// interval timer, keeps running while a refresh waits
	// ----------------------------------------------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			tmr  <= '0;
			pend <= 1'b0;
		end else begin
			if (!enable || expire)
				tmr <= '0;
			else
				tmr <= tmr + 1'b1;
			if (expire)
				pend <= 1'b1;
			else if (start)
				pend <= 1'b0; // AREF goes out next cycle
		end
	end

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state   <= A_IDLE;
			rfc_cnt <= '0;
		end else begin
			case (state)
				A_IDLE: if (start) state <= A_AREF;
				A_AREF: begin
					state   <= A_RFC;
					rfc_cnt <= '0;
				end
				default: begin
					if (done)
						state <= A_IDLE;
					else
						rfc_cnt <= rfc_cnt + 1'b1;
				end
			endcase
		end
	end

	assign done = (state == A_RFC) && (rfc_cnt == FW'(`SDRAM_TRFC - 1));

	always_comb begin
		cmd = sdram_cmd_pkg::CMD_IDLE;
		if (state == A_AREF)
			cmd.cmd = sdram_cmd_pkg::AREF;
	end

endmodule

// File: sdram_cmd_pkg.sv
package sdram_cmd_pkg;

	// ----------------------------------------------------------
	// pin-level commands as {cs_n, ras_n, cas_n, we_n}
	// ----------------------------------------------------------
	typedef enum logic [3:0] {
		MRS  = 4'b0000,
		AREF = 4'b0001,
		PREC = 4'b0010,
		ACT  = 4'b0011,
		READ = 4'b0101,
		NOP  = 4'b0111
	} cmd_e;

	// address pins as seen by READ and PREC
	typedef struct packed {
		logic       a11;  // unused
		logic       a10;  // precharge all on PREC
		logic [1:0] a9_8; // unused
		logic [7:0] col;
	} col_addr_t;

	// ACT and MRS take the whole word as a row or mode value
	typedef union packed {
		logic [11:0] row;
		col_addr_t   colv;
	} addr_u;

	typedef struct packed {
		cmd_e  cmd;
		addr_u addr;
	} cmd_bus_t;

	localparam cmd_bus_t CMD_IDLE = {NOP, 12'h000};

	localparam cmd_bus_t CMD_PREC_ALL = {PREC, 12'h400}; // a10 set

endpackage

// File: sdram_ctrl_sva.sv
`include "sdram_params.svh"

module sdram_ctrl_sva (
	input logic                    S_CLK,
	input logic                    RST_N,
	input logic                    rd_req,
	input sdram_req_pkg::rd_req_t  rd_info,
	input sdram_cmd_pkg::cmd_bus_t sdram,
	input sdram_req_pkg::rd_data_t rd_out,
	input logic                    rd_done,
	input logic                    init_done,
	input logic                    aref_pend,
	input logic                    read_yield
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] COL_LAST = 8'(256 - `SDRAM_BURST_LEN);

	int          fail_cnt = 0;
	logic        is_nop;
	logic        is_act;
	logic        is_read;
	logic        is_prec;
	logic        is_aref;
	logic        is_mrs;
	logic        row_open;   // between ACT and PREC on the pins
	logic [11:0] act_row;
	logic [11:0] exp_row;    // row the next ACT must carry
	logic [7:0]  exp_col;    // column the next READ must carry
	logic [7:0]  burst_col;
	logic [7:0]  word_idx;
	logic [15:0] exp_data;
	int          words_left; // words still owed to the open request
	logic        req_open;

	assign is_nop   = (sdram.cmd == sdram_cmd_pkg::NOP);
	assign is_act   = (sdram.cmd == sdram_cmd_pkg::ACT);
	assign is_read  = (sdram.cmd == sdram_cmd_pkg::READ);
	assign is_prec  = (sdram.cmd == sdram_cmd_pkg::PREC);
	assign is_aref  = (sdram.cmd == sdram_cmd_pkg::AREF);
	assign is_mrs   = (sdram.cmd == sdram_cmd_pkg::MRS);
	assign exp_data = {act_row[7:0], burst_col + word_idx}; // memory pattern

	task automatic count_fail(input string msg);
		fail_cnt++;
		$error("%s", msg);
	endtask

	// ----------------------------------------------------------
	// trackers built from the pins and the request
	// ----------------------------------------------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			row_open   <= 1'b0;
			act_row    <= '0;
			exp_row    <= '0;
			exp_col    <= '0;
			burst_col  <= '0;
			word_idx   <= '0;
			words_left <= 0;
			req_open   <= 1'b0;
		end else begin
			if (rd_req) begin
				exp_row    <= rd_info.row;
				exp_col    <= rd_info.col;
				words_left <= rd_info.nbursts * `SDRAM_BURST_LEN;
				req_open   <= 1'b1;
			end
			if (is_act) begin
				row_open <= 1'b1;
				act_row  <= sdram.addr.row;
			end
			if (is_prec)
				row_open <= 1'b0;
			if (is_read) begin
				burst_col <= sdram.addr.colv.col;
				word_idx  <= '0;
				exp_col   <= sdram.addr.colv.col + 8'(`SDRAM_BURST_LEN); // wraps at row end
				if (sdram.addr.colv.col == COL_LAST)
					exp_row <= exp_row + 12'd1;
			end
			if (rd_out.valid) begin
				word_idx   <= word_idx + 8'd1;
				words_left <= words_left - 1;
			end
			if (rd_done)
				req_open <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// power-up
	// ----------------------------------------------------------
	init_order: assert property (@(posedge S_CLK) $rose(RST_N) |=>
		is_nop [*`SDRAM_INIT_WAIT]
		##1 (is_prec && sdram.addr.colv.a10)
		##1 is_aref ##1 is_nop [*`SDRAM_TRFC]
		##1 is_aref ##1 is_nop [*`SDRAM_TRFC]
		##1 (is_mrs && !init_done) ##1 init_done)
		else count_fail("power-up command sequence is out of order");

	no_early_access: assert property (@(posedge S_CLK) disable iff (!RST_N)
		!init_done |-> !(is_act || is_read))
		else count_fail("ACT or READ issued before init finished");

	done_after_mrs: assert property (@(posedge S_CLK) disable iff (!RST_N)
		$rose(init_done) |-> $past(is_mrs))
		else count_fail("init_done rose without MRS in the cycle before");

	// ----------------------------------------------------------
	// read commands
	// ----------------------------------------------------------
	act_after_req: assert property (@(posedge S_CLK) disable iff (!RST_N)
		rd_req && !aref_pend |-> ##3 is_act ##1 is_read)
		else count_fail("ACT and READ did not follow the request on time");

	act_row_ok: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_act |-> sdram.addr.row == exp_row)
		else count_fail($sformatf("ERR sdram.addr.row got %h exp %h",
			$sampled(sdram.addr.row), $sampled(exp_row)));

	read_col_ok: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_read |-> sdram.addr.colv.col == exp_col)
		else count_fail($sformatf("ERR sdram.addr.colv.col got %h exp %h",
			$sampled(sdram.addr.colv.col), $sampled(exp_col)));

	read_aligned: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_read |-> (sdram.addr.colv.col % `SDRAM_BURST_LEN) == 0)
		else count_fail("READ column is not burst aligned");

	read_row_open: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_read |-> row_open)
		else count_fail("READ issued with no open row");

	row_cross: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_prec && init_done && !rd_done && !read_yield |->
		##1 is_nop [*`SDRAM_TRP] ##1 is_act)
		else count_fail("row crossing did not reopen a row after PREC");

	// ----------------------------------------------------------
	// refresh and data
	// ----------------------------------------------------------
	aref_closed: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_aref |-> !row_open)
		else count_fail("AREF issued while a row was open");

	yield_to_aref: assert property (@(posedge S_CLK) disable iff (!RST_N)
		read_yield |-> ##[1:6] is_aref)
		else count_fail("no AREF followed the read yield");

	burst_window: assert property (@(posedge S_CLK) disable iff (!RST_N)
		is_read |-> (!rd_out.valid) [*`SDRAM_CAS_LAT + 1]
		##1 rd_out.valid [*`SDRAM_BURST_LEN] ##1 !rd_out.valid)
		else count_fail("valid words after READ have the wrong timing");

	data_ok: assert property (@(posedge S_CLK) disable iff (!RST_N)
		rd_out.valid |-> rd_out.data == exp_data)
		else count_fail($sformatf("ERR rd_out.data got %h exp %h",
			$sampled(rd_out.data), $sampled(exp_data)));

	word_owed: assert property (@(posedge S_CLK) disable iff (!RST_N)
		rd_out.valid |-> words_left > 0)
		else count_fail("more valid words than the request asked for");

	done_last: assert property (@(posedge S_CLK) disable iff (!RST_N)
		rd_done |-> req_open && words_left == 0)
		else count_fail("rd_done came early or without a request");

	done_pulse: assert property (@(posedge S_CLK) disable iff (!RST_N)
		rd_done |=> !rd_done)
		else count_fail("rd_done is longer than one cycle");

	req_after_done: assert property (@(posedge S_CLK) disable iff (!RST_N)
		rd_req |-> !req_open)
		else count_fail("new request before the previous rd_done");

endmodule

bind sdram_ctrl_top sdram_ctrl_sva u_sva (
	.S_CLK      (S_CLK),
	.RST_N      (RST_N),
	.rd_req     (rd_req),
	.rd_info    (rd_info),
	.sdram      (sdram),
	.rd_out     (rd_out),
	.rd_done    (rd_done),
	.init_done  (init_done),
	.aref_pend  (aref_pend),
	.read_yield (read_yield)
);

// File: sdram_ctrl_top.sv
module sdram_ctrl_top (
	input  logic                    S_CLK,
	input  logic                    RST_N,
	input  logic                    rd_req,
	input  sdram_req_pkg::rd_req_t  rd_info,
	input  logic [15:0]             dq,
	output sdram_cmd_pkg::cmd_bus_t sdram,
	output sdram_req_pkg::rd_data_t rd_out,
	output logic                    rd_done,
	output logic                    init_done
);

	sdram_cmd_pkg::cmd_bus_t init_cmd;
	sdram_cmd_pkg::cmd_bus_t aref_cmd;
	sdram_cmd_pkg::cmd_bus_t read_cmd;
	logic                    init_done_pulse;
	logic                    aref_start;
	logic                    aref_pend;
	logic                    aref_done;
	logic                    read_start;
	logic                    read_yield;

	sdram_init u_init (
		.S_CLK (S_CLK),
		.RST_N (RST_N),
		.cmd   (init_cmd),
		.done  (init_done_pulse)
	);

	sdram_aref u_aref (
		.S_CLK  (S_CLK),
		.RST_N  (RST_N),
		.enable (init_done),
		.start  (aref_start),
		.pend   (aref_pend),
		.done   (aref_done),
		.cmd    (aref_cmd)
	);

	sdram_read u_read (
		.S_CLK     (S_CLK),
		.RST_N     (RST_N),
		.start     (read_start),
		.req       (rd_info),
		.aref_pend (aref_pend),
		.dq        (dq),
		.cmd       (read_cmd),
		.yield     (read_yield),
		.done      (rd_done),
		.rd_out    (rd_out)
	);

	sdram_arbiter u_arbiter (
		.S_CLK           (S_CLK),
		.RST_N           (RST_N),
		.init_done_pulse (init_done_pulse),
		.rd_req          (rd_req),
		.aref_pend       (aref_pend),
		.aref_done       (aref_done),
		.rd_yield        (read_yield),
		.rd_done         (rd_done),
		.init_cmd        (init_cmd),
		.aref_cmd        (aref_cmd),
		.read_cmd        (read_cmd),
		.aref_start      (aref_start),
		.read_start      (read_start),
		.init_done       (init_done),
		.sdram           (sdram)
	);

endmodule

// File: sdram_init.sv
`include "sdram_params.svh"

module sdram_init (
	input  logic                    S_CLK,
	input  logic                    RST_N,
	output sdram_cmd_pkg::cmd_bus_t cmd,
	output logic                    done
);

	localparam int CW = $clog2(`SDRAM_INIT_WAIT + 1);

	// A6:A4 cas latency, A3 sequential, A2:A0 burst length code
	localparam logic [11:0] MODE_WORD = {5'b00000, 3'(`SDRAM_CAS_LAT), 1'b0,
		3'($clog2(`SDRAM_BURST_LEN))};

	typedef enum logic [2:0] {I_WAIT, I_PREC, I_AREF, I_RFC, I_MRS, I_END} init_e;

	init_e         state;
	logic [CW-1:0] cnt;
	logic          second; // second refresh under way

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state  <= I_WAIT;
			cnt    <= '0;
			second <= 1'b0;
			done   <= 1'b0;
		end else begin
			done <= (state == I_MRS); // one cycle, lines up with MRS on the pins
			case (state)
				I_WAIT: begin
					if (cnt == CW'(`SDRAM_INIT_WAIT - 1)) begin
						state <= I_PREC;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				I_PREC: state <= I_AREF;
				I_AREF: begin
					state <= I_RFC;
					cnt   <= '0;
				end
				I_RFC: begin
					if (cnt == CW'(`SDRAM_TRFC - 1)) begin
						state  <= second ? I_MRS : I_AREF;
						second <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= I_END; // MRS and after, parked for good
			endcase
		end
	end

	always_comb begin
		cmd = sdram_cmd_pkg::CMD_IDLE;
		case (state)
			I_PREC: cmd = sdram_cmd_pkg::CMD_PREC_ALL;
			I_AREF: cmd.cmd = sdram_cmd_pkg::AREF;
			I_MRS: begin
				cmd.cmd      = sdram_cmd_pkg::MRS;
				cmd.addr.row = MODE_WORD;
			end
			default: cmd = sdram_cmd_pkg::CMD_IDLE;
		endcase
	end

endmodule

// File: sdram_params.svh
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// ----------------------------------------------------------
// burst shape, also programmed into the mode register
// ----------------------------------------------------------
`define SDRAM_BURST_LEN 4 // words per READ, power of two

`define SDRAM_CAS_LAT 2 // READ to first word on dq

// ----------------------------------------------------------
// timing in S_CLK cycles, shortened for simulation
// ----------------------------------------------------------
`define SDRAM_REF_PERIOD 200 // between refresh requests

`define SDRAM_INIT_WAIT 20 // power-up NOPs

`define SDRAM_TRP 1 // NOPs after a row precharge

`define SDRAM_TRFC 3 // NOPs after each AREF

`endif

// File: sdram_read.sv
`include "sdram_params.svh"

module sdram_read (
	input  logic                    S_CLK,
	input  logic                    RST_N,
	input  logic                    start,
	input  sdram_req_pkg::rd_req_t  req,
	input  logic                    aref_pend,
	input  logic [15:0]             dq,
	output sdram_cmd_pkg::cmd_bus_t cmd,
	output logic                    yield,
	output logic                    done,
	output sdram_req_pkg::rd_data_t rd_out
);

	localparam logic [3:0] CAS_LAST   = 4'(`SDRAM_CAS_LAT - 1);
	localparam logic [3:0] BURST_LAST = 4'(`SDRAM_BURST_LEN - 1);
	localparam logic [3:0] TRP_LAST   = 4'(`SDRAM_TRP - 1);
	localparam logic [7:0] COL_STEP   = 8'(`SDRAM_BURST_LEN);
	localparam logic [7:0] COL_LAST   = 8'(256 - `SDRAM_BURST_LEN);

	typedef enum logic [2:0] {
		S_IDLE, S_ACT, S_READ, S_CAS, S_BURST, S_PREC, S_TRP
	} rd_state_e;

	rd_state_e              state;
	logic [3:0]             cnt;         // cas, burst and trp waits
	logic [11:0]            row_cnt;
	logic [7:0]             col_cnt;
	logic [5:0]             bursts_left; // nonzero while idle means yielded
	logic                   end_yield;   // this PREC hands over to refresh
	logic                   end_done;    // this PREC ends the request
	sdram_req_pkg::rd_req_t req_q;
	logic                   rd_vld;
	logic [15:0]            rd_word;

	// rd_info is only valid with its strobe, a zero burst count is no request
	always_ff @(posedge S_CLK) begin
		if (state == S_IDLE && bursts_left == '0 && req.nbursts != '0)
			req_q <= req;
	end

	// ----------------------------------------------------------
	// command sequencing
	// ----------------------------------------------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state       <= S_IDLE;
			cnt         <= '0;
			row_cnt     <= '0;
			col_cnt     <= '0;
			bursts_left <= '0;
			end_yield   <= 1'b0;
			end_done    <= 1'b0;
			yield       <= 1'b0;
			done        <= 1'b0;
		end else begin
			yield <= 1'b0;
			done  <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						state     <= S_ACT;
						end_yield <= 1'b0;
						end_done  <= 1'b0;
						if (bursts_left == '0) begin // fresh, else resume where we left
							row_cnt     <= req_q.row;
							col_cnt     <= req_q.col & ~(COL_STEP - 8'd1);
							bursts_left <= req_q.nbursts;
						end
					end
				end
				S_ACT: state <= S_READ;
				S_READ: begin
					state       <= S_CAS;
					cnt         <= '0;
					bursts_left <= bursts_left - 6'd1;
				end
				S_CAS: begin
					if (cnt == CAS_LAST) begin
						state <= S_BURST;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				S_BURST: begin
					if (cnt == BURST_LAST) begin
						cnt     <= '0;
						col_cnt <= col_cnt + COL_STEP; // wraps to 0 on the last column
						if (col_cnt == COL_LAST)
							row_cnt <= row_cnt + 12'd1;
						if (bursts_left == '0) begin
							state    <= S_PREC;
							end_done <= 1'b1;
						end else if (aref_pend) begin
							state     <= S_PREC;
							end_yield <= 1'b1;
						end else if (col_cnt == COL_LAST) begin
							state <= S_PREC; // row crossing
						end else begin
							state <= S_READ;
						end
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				S_PREC: begin
					yield <= end_yield; // high while PREC is on the pins
					done  <= end_done;
					cnt   <= '0;
					state <= (end_yield || end_done) ? S_IDLE : S_TRP;
				end
				S_TRP: begin
					if (cnt == TRP_LAST)
						state <= S_ACT;
					else
						cnt <= cnt + 4'd1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_comb begin
		cmd = sdram_cmd_pkg::CMD_IDLE;
		case (state)
			S_ACT: begin
				cmd.cmd      = sdram_cmd_pkg::ACT;
				cmd.addr.row = row_cnt;
			end
			S_READ: begin
				cmd.cmd           = sdram_cmd_pkg::READ;
				cmd.addr.colv.col = col_cnt; // a10 low, no auto precharge
			end
			S_PREC:  cmd = sdram_cmd_pkg::CMD_PREC_ALL;
			default: cmd = sdram_cmd_pkg::CMD_IDLE;
		endcase
	end

	// ----------------------------------------------------------
	// data capture
	// ----------------------------------------------------------
	// the arbiter adds one cycle to READ, so burst cycles match dq word for word
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N)
			rd_vld <= 1'b0;
		else
			rd_vld <= (state == S_BURST);
	end

	always_ff @(posedge S_CLK) begin
		rd_word <= dq;
	end

	assign rd_out = '{valid: rd_vld, data: rd_word};

endmodule

// File: sdram_req_pkg.sv
package sdram_req_pkg;

	// user read request, one strobe per request
	typedef struct packed {
		logic [11:0] row;
		logic [7:0]  col;     // first column, burst aligned
		logic [5:0]  nbursts; // READ commands in this request
	} rd_req_t;

	// one returned word per valid cycle
	typedef struct packed {
		logic        valid;
		logic [15:0] data;
	} rd_data_t;

	// owner of the command bus
	typedef enum logic [1:0] {
		G_INIT,
		G_IDLE,
		G_AREF,
		G_READ
	} grant_e;

endpackage

// File: tb_sdram_ctrl.sv
`include "sdram_params.svh"

module tb_sdram_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int         PIPE     = `SDRAM_CAS_LAT + `SDRAM_BURST_LEN;
	localparam int         LIMIT    = 3000; // cycles per wait
	localparam logic [7:0] COL_MASK = 8'(~(`SDRAM_BURST_LEN - 1));

	logic                    S_CLK;
	logic                    RST_N;
	logic                    rd_req;
	sdram_req_pkg::rd_req_t  rd_info;
	logic [15:0]             dq;
	sdram_cmd_pkg::cmd_bus_t sdram;
	sdram_req_pkg::rd_data_t rd_out;
	logic                    rd_done;
	logic                    init_done;

	logic [31:0] lfsr;
	logic [11:0] model_row;     // row opened by the last ACT
	logic [15:0] dq_pipe [PIPE]; // index 0 is the current cycle

	sdram_ctrl_top uut (
		.S_CLK     (S_CLK),
		.RST_N     (RST_N),
		.rd_req    (rd_req),
		.rd_info   (rd_info),
		.dq        (dq),
		.sdram     (sdram),
		.rd_out    (rd_out),
		.rd_done   (rd_done),
		.init_done (init_done)
	);

	initial begin
		S_CLK = 1'b0;
		forever #20 S_CLK = ~S_CLK;
	end

	task automatic stop_run(input string why);
		$display("Checks failed");
		$fatal(1, "%s", why);
	endtask

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// ----------------------------------------------------------
	// SDRAM data model
	// ----------------------------------------------------------
	always @(negedge S_CLK) begin : mem_model
		int k;
		for (k = 0; k < PIPE - 1; k++)
			dq_pipe[k] = dq_pipe[k + 1];
		dq_pipe[PIPE - 1] = '0;
		if (sdram.cmd == sdram_cmd_pkg::ACT)
			model_row = sdram.addr.row;
		if (sdram.cmd == sdram_cmd_pkg::READ) begin
			for (k = 0; k < `SDRAM_BURST_LEN; k++) // word = {row low byte, column}
				dq_pipe[`SDRAM_CAS_LAT + k] = {model_row[7:0], sdram.addr.colv.col + 8'(k)};
		end
		dq = dq_pipe[0];
	end

	always @(negedge S_CLK) begin
		if (uut.u_sva.fail_cnt != 0)
			stop_run("an assertion failed");
	end

	task automatic wait_init();
		int t;
		t = 0;
		while (!init_done && t < LIMIT) begin
			@(negedge S_CLK);
			t++;
		end
		if (!init_done)
			stop_run("init_done never rose");
	endtask

	// one request, sent only while the arbiter idles with no refresh waiting
	task automatic send_read(input logic [11:0] start_row, input logic [7:0] start_col,
		input logic [5:0] bursts);
		int t;
		t = 0;
		while ((uut.u_arbiter.grant != sdram_req_pkg::G_IDLE || uut.aref_pend) && t < LIMIT) begin
			@(negedge S_CLK);
			t++;
		end
		if (t >= LIMIT)
			stop_run("controller did not return to idle");
		rd_req  = 1'b1;
		rd_info = '{row: start_row, col: start_col, nbursts: bursts};
		@(negedge S_CLK);
		rd_req  = 1'b0;
		rd_info = '0;
		t = 0;
		while (!rd_done && t < LIMIT) begin
			@(negedge S_CLK);
			t++;
		end
		if (!rd_done)
			stop_run("rd_done never came for the request");
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		int          n;
		logic [31:0] r;
		logic [11:0] row;
		logic [7:0]  col;
		RST_N   = 1'b0;
		rd_req  = 1'b0;
		rd_info = '0;
		dq      = '0;
		lfsr    = 32'haa4e;
		for (n = 0; n < PIPE; n++)
			dq_pipe[n] = '0;
		repeat (8) @(posedge S_CLK);
		@(negedge S_CLK);
		RST_N = 1'b1;
		wait_init();
		for (n = 0; n < 4; n++) begin // short random requests
			take_bits(12, r);
			row = r[11:0];
			take_bits(8, r);
			col = r[7:0] & COL_MASK;
			take_bits(3, r);
			send_read(row, col, 6'(r[2:0]) + 6'd1);
		end
		take_bits(12, r);
		send_read(r[11:0], 8'(256 - 2 * `SDRAM_BURST_LEN), 6'd4); // crosses a row
		take_bits(12, r);
		row = r[11:0];
		take_bits(8, r);
		send_read(row, r[7:0] & COL_MASK, 6'd60); // outlasts the refresh period
		repeat (20) @(negedge S_CLK);
		if (uut.u_sva.fail_cnt != 0) begin
			stop_run("assertion failures at the end of the run");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule
